//--- canvas_ram.sv
/* 64x32 canvas at 4 bits per pixel, written by the filler and read by the
   display scanner with one cycle of latency */
`default_nettype none
`timescale 1ns/1ps

module canvas_ram (
    input  logic                clk_sys,
    canvas_wr_if.sink           wr,
    input  gfx_pkg::canv_addr_t rd_addr,
    output gfx_pkg::colr_idx_t  rd_colr
);
    import gfx_pkg::*;

    localparam int DEPTH = CANV_W * CANV_H;

    colr_idx_t  mem [DEPTH];
    canv_addr_t wr_addr;

    assign wr_addr = {wr.wr_y, 6'd0} + {5'd0, wr.wr_x};  // row * 64 + column

    always_ff @(posedge clk_sys) begin
        if (wr.wr_en) mem[wr_addr] <= wr.wr_colr;
        rd_colr <= mem[rd_addr];  // registered read
    end

    // a write never lands at an unknown address or with an unknown colour
    a_wr_known: assert property (@(posedge clk_sys)
        wr.wr_en |-> !$isunknown({wr.wr_x, wr.wr_y, wr.wr_colr}))
        else $error("canvas_ram: write with unknown address or colour");
endmodule

`default_nettype wire

//--- display_scan.sv
/* video timing and pixel pipeline: fetches the scaled canvas inside the window,
   maps it through the palette and fills the rest with the background colour */
`default_nettype none
`timescale 1ns/1ps

module display_scan #(
    parameter int H_ACTIVE     = 160,
    parameter int H_TOTAL      = 200,
    parameter int H_SYNC_START = 168,
    parameter int H_SYNC_LEN   = 16,
    parameter int V_ACTIVE     = 80,
    parameter int V_TOTAL      = 90,
    parameter int V_SYNC_START = 82,
    parameter int V_SYNC_LEN   = 2,
    parameter int CANV_SCALE   = 2,
    parameter int WIN_STARTX   = 16,
    parameter int WIN_STARTY   = 8
) (
    input  logic                clk_sys,
    input  logic                rst_sys,
    output gfx_pkg::canv_addr_t rd_addr,
    input  gfx_pkg::colr_idx_t  rd_colr,
    output gfx_pkg::colr_idx_t  pal_idx,
    input  gfx_pkg::rgb555_t    pal_colr,
    input  gfx_pkg::rgb555_t    bg_colr,
    output logic                hsync,
    output logic                vsync,
    output logic                de,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue
);
    import gfx_pkg::*;

    localparam int HW    = $clog2(H_TOTAL);
    localparam int VW    = $clog2(V_TOTAL);
    localparam int WIN_W = CANV_W * CANV_SCALE;  // window size in display pixels
    localparam int WIN_H = CANV_H * CANV_SCALE;

    logic [HW-1:0] h_cnt, h_off;
    logic [VW-1:0] v_cnt, v_off;
    logic          act_0, win_0, hs_0, vs_0;  // stage 0 from the counters
    logic          act_1, win_1, hs_1, vs_1;  // stage 1 as canvas data arrives
    rgb555_t       pix_colr;

    // 5 to 8 bits, top bits repeated into the low end so full scale stays 255
    function automatic logic [7:0] expand(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign act_0 = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign hs_0  = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_START + H_SYNC_LEN);
    assign vs_0  = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_START + V_SYNC_LEN);
    assign win_0 = (h_cnt >= WIN_STARTX) && (h_cnt < WIN_STARTX + WIN_W) &&
                   (v_cnt >= WIN_STARTY) && (v_cnt < WIN_STARTY + WIN_H);

    // canvas coordinate, only meaningful inside the window
    assign h_off   = h_cnt - HW'(WIN_STARTX);
    assign v_off   = v_cnt - VW'(WIN_STARTY);
    assign rd_addr = {canv_y_t'(v_off / CANV_SCALE), canv_x_t'(h_off / CANV_SCALE)};

    assign pal_idx  = rd_colr;                      // read data lands in stage 1
    assign pix_colr = win_1 ? pal_colr : bg_colr;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            {act_1, win_1, hs_1, vs_1} <= '0;
            {de, hsync, vsync}         <= '0;
        end else begin
            {act_1, win_1, hs_1, vs_1} <= {act_0, win_0, hs_0, vs_0};
            {de, hsync, vsync}         <= {act_1, hs_1, vs_1};  // aligned with colour
        end
    end

    always_ff @(posedge clk_sys) begin  // black during blanking
        red   <= act_1 ? expand(pix_colr[14:10]) : 8'd0;
        green <= act_1 ? expand(pix_colr[9:5]) : 8'd0;
        blue  <= act_1 ? expand(pix_colr[4:0]) : 8'd0;
    end

    a_sync_blank: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !(hsync && de))
        else $error("display_scan: hsync during active video");
endmodule

`default_nettype wire

//--- draw_ctrl.sv
/* walks the command list after a start pulse, drops malformed rectangles and
   hands the rest to the filler one at a time, reporting busy and done */
`default_nettype none
`timescale 1ns/1ps

module draw_ctrl (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  logic               start,
    input  gfx_pkg::cmd_cnt_t  cmd_count,
    output gfx_pkg::cmd_idx_t  cmd_idx,
    input  gfx_pkg::cmd_word_t cmd_word,
    output logic               busy,
    output logic               done,
    draw_cmd_if.source         cmd
);
    import gfx_pkg::*;

    draw_state_t state;
    cmd_cnt_t    cmd_pos;     // one bit wider than cmd_idx so it can reach 16
    canv_x_t     w_x0, w_x1;
    canv_y_t     w_y0, w_y1;
    logic        bad_rect;

    // unpack the word at cmd_pos, top 6 bits unused
    assign w_x0     = cmd_word[25:20];
    assign w_y0     = cmd_word[19:15];
    assign w_x1     = cmd_word[14:9];
    assign w_y1     = cmd_word[8:4];
    assign bad_rect = (w_x0 > w_x1) || (w_y0 > w_y1);
    assign cmd_idx  = cmd_pos[3:0];

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state     <= IDLE;
            cmd_pos   <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd.valid <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    state <= IDLE;
                    if (start) begin
                        state   <= FETCH;
                        cmd_pos <= '0;
                        busy    <= 1'b1;
                        done    <= 1'b0;  // held until this new start
                    end
                end
                FETCH: begin
                    if (cmd_pos >= cmd_count) begin  // list exhausted
                        state <= DONE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else if (bad_rect) begin
                        cmd_pos <= cmd_pos + 1'b1;  // skip without issue
                    end else begin
                        cmd.x0    <= w_x0;
                        cmd.y0    <= w_y0;
                        cmd.x1    <= w_x1;
                        cmd.y1    <= w_y1;
                        cmd.colr  <= cmd_word[3:0];
                        cmd.valid <= 1'b1;
                        state     <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (cmd.ready) begin  // transfer this edge
                        cmd.valid <= 1'b0;
                        cmd_pos   <= cmd_pos + 1'b1;
                        state     <= WAIT_FILL;
                    end
                end
                WAIT_FILL: begin
                    if (cmd.ready) state <= FETCH;  // filler back, rect done
                end
                default: state <= IDLE;
            endcase
        end
    end

    // an offered command stays put until the filler takes it
    a_valid_hold: assert property (@(posedge clk_sys) disable iff (rst_sys)
        (cmd.valid && !cmd.ready) |=>
        (cmd.valid && $stable({cmd.x0, cmd.y0, cmd.x1, cmd.y1, cmd.colr})))
        else $error("draw_ctrl: command withdrawn before transfer");
endmodule

`default_nettype wire

//--- gfx_apb_regs.sv
/* zero-wait APB slave with control, status, background, palette and command list
   registers, with combinational lookups for the draw controller and scanner */
`default_nettype none
`timescale 1ns/1ps

module gfx_apb_regs (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  gfx_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  gfx_pkg::apb_data_t pwdata,
    output gfx_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               start,
    output gfx_pkg::cmd_cnt_t  cmd_count,
    input  gfx_pkg::cmd_idx_t  cmd_idx,
    output gfx_pkg::cmd_word_t cmd_word,
    input  logic               busy,
    input  logic               done,
    output gfx_pkg::rgb555_t   bg_colr,
    input  gfx_pkg::colr_idx_t pal_idx,
    output gfx_pkg::rgb555_t   pal_colr
);
    import gfx_pkg::*;

    logic       access, hit_pal, hit_cmd, mapped, wr_ok;
    logic [3:0] slot;                // word slot inside palette or command window
    rgb555_t    pal_mem [CMD_MAX];
    cmd_word_t  cmd_mem [CMD_MAX];
    apb_data_t  rd_mux;

    assign access  = psel && penable;
    assign slot    = paddr[5:2];
    assign hit_pal = (paddr[7:6] == PAL_BASE[7:6]) && (paddr[1:0] == 2'b00);
    assign hit_cmd = (paddr[7:6] == CMD_BASE[7:6]) && (paddr[1:0] == 2'b00);
    assign mapped  = hit_pal || hit_cmd ||
                     (paddr inside {REG_CTRL, REG_STATUS, REG_BG, REG_CMD_COUNT});

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = access && (!mapped || (pwrite && paddr == REG_STATUS));
    assign wr_ok   = access && pwrite && !pslverr;

    always_comb begin
        rd_mux = '0;  // CTRL reads back zero
        case (paddr)
            REG_STATUS:    rd_mux = {30'd0, done, busy};  // live from draw_ctrl
            REG_BG:        rd_mux = apb_data_t'(bg_colr);
            REG_CMD_COUNT: rd_mux = apb_data_t'(cmd_count);
            default: begin
                if (hit_pal) rd_mux = apb_data_t'(pal_mem[slot]);
                if (hit_cmd) rd_mux = cmd_mem[slot];
            end
        endcase
    end
    assign prdata = (access && !pwrite && !pslverr) ? rd_mux : '0;

    assign cmd_word = cmd_mem[cmd_idx];
    assign pal_colr = pal_mem[pal_idx];

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            start     <= 1'b0;
            bg_colr   <= '0;
            cmd_count <= '0;
            for (int i = 0; i < CMD_MAX; i++) begin
                pal_mem[i] <= '0;
                cmd_mem[i] <= '0;
            end
        end else begin
            start <= wr_ok && (paddr == REG_CTRL) && pwdata[0] && !busy;  // one-cycle pulse
            if (wr_ok && paddr == REG_BG) bg_colr <= pwdata[14:0];
            if (wr_ok && paddr == REG_CMD_COUNT)
                cmd_count <= (pwdata > CMD_MAX) ? cmd_cnt_t'(CMD_MAX) : pwdata[4:0];
            if (wr_ok && hit_pal) pal_mem[slot] <= pwdata[14:0];
            if (wr_ok && hit_cmd) cmd_mem[slot] <= pwdata;
        end
    end

    // a CTRL write gives exactly one start cycle
    a_start_pulse: assert property (@(posedge clk_sys) disable iff (rst_sys)
        start |=> !start)
        else $error("gfx_apb_regs: start held for more than one cycle");
endmodule

`default_nettype wire

//--- gfx_checker.sv
/* testbench monitor for gfx_top: compares APB responses on request and checks
   queued display pixels and line sync over one full video frame */
`default_nettype none
`timescale 1ns/1ps

module gfx_checker (
    input  logic        clk_sys,
    input  logic [31:0] prdata,
    input  logic        pslverr,
    input  logic        de,
    input  logic        hsync,
    input  logic        vsync,
    input  logic [7:0]  red,
    input  logic [7:0]  green,
    input  logic [7:0]  blue
);
    localparam int SYNC_LEN    = 16;  // hsync width in clocks
    localparam int FRAME_LINES = 90;  // one hsync per line between vsync starts

    int          errors;
    int          checks;
    int          n_pts;           // queued pixel points
    int          col, row;        // display position from de and vsync
    int          hs_len;          // clocks since hsync rose
    int          n_hs;            // hsync pulses in the frame being checked
    logic        armed;           // waiting for the next frame start
    logic        capturing;       // inside the frame being checked
    logic        frame_done;
    logic        de_q, vs_q, hs_q;
    int          pt_x [64];
    int          pt_y [64];
    logic [23:0] pt_rgb [64];     // expected red, green, blue
    logic        pt_hit [64];

    initial begin
        errors     = 0;
        checks     = 0;
        n_pts      = 0;
        col        = 0;
        row        = 0;
        hs_len     = 0;
        n_hs       = 0;
        armed      = 1'b0;
        capturing  = 1'b0;
        frame_done = 1'b0;
        de_q       = 1'b0;
        vs_q       = 1'b0;
        hs_q       = 1'b0;
    end

    task automatic compare_response(input logic [7:0] addr, input logic check_data,
            input logic [31:0] exp_data, input logic exp_err);
        checks++;
        if (pslverr !== exp_err) begin
            $display("Error: time %0t, pslverr at 0x%02h: expected %0b, actual %0b",
                     $time, addr, exp_err, pslverr);
            errors++;
        end
        if (check_data && prdata !== exp_data) begin
            $display("Error: time %0t, prdata at 0x%02h: expected 0x%08h, actual 0x%08h",
                     $time, addr, exp_data, prdata);
            errors++;
        end
    endtask

    task automatic add_point(input int x, input int y, input logic [7:0] r,
            input logic [7:0] g, input logic [7:0] b);
        if (n_pts < 64) begin
            pt_x[n_pts]   = x;
            pt_y[n_pts]   = y;
            pt_rgb[n_pts] = {r, g, b};
            pt_hit[n_pts] = 1'b0;
            n_pts++;
        end else begin
            $display("more than 64 pixel points queued for one frame");
            errors++;
        end
    endtask

    task automatic arm_frame();
        frame_done = 1'b0;
        armed      = 1'b1;
    endtask

    task automatic compare_channel(input string name, input int x, input int y,
            input logic [7:0] exp_v, input logic [7:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("Error: time %0t, %s at (%0d,%0d): expected %0d, actual %0d",
                     $time, name, x, y, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_pixel(input int x, input int y);
        for (int i = 0; i < n_pts; i++) begin
            if (pt_x[i] == x && pt_y[i] == y) begin
                pt_hit[i] = 1'b1;
                compare_channel("red", x, y, pt_rgb[i][23:16], red);
                compare_channel("green", x, y, pt_rgb[i][15:8], green);
                compare_channel("blue", x, y, pt_rgb[i][7:0], blue);
            end
        end
    endtask

    task automatic check_sync_width();
        checks++;
        if (hs_len != SYNC_LEN) begin
            $display("Error: time %0t, hsync width: expected %0d, actual %0d",
                     $time, SYNC_LEN, hs_len);
            errors++;
        end
    endtask

    task automatic close_frame();
        for (int i = 0; i < n_pts; i++) begin
            if (!pt_hit[i]) begin  // point outside the active area
                $display("pixel (%0d,%0d) never showed up as an active pixel", pt_x[i], pt_y[i]);
                errors++;
            end
        end
        checks++;
        if (n_hs != FRAME_LINES) begin
            $display("Error: time %0t, hsync pulses per frame: expected %0d, actual %0d",
                     $time, FRAME_LINES, n_hs);
            errors++;
        end
        n_pts      = 0;
        frame_done = 1'b1;
    endtask

    // mid-cycle sampling, outputs are registered on the rising edge
    always @(negedge clk_sys) begin
        if (vsync && !vs_q) begin  // frame boundary
            row = 0;
            col = 0;
            if (capturing) begin
                capturing = 1'b0;
                close_frame();
            end else if (armed) begin
                armed     = 1'b0;
                capturing = 1'b1;
                n_hs      = 0;
            end
        end
        if (de) begin
            if (capturing) check_pixel(col, row);
            col++;
        end else if (de_q) begin  // active line just ended
            col = 0;
            row++;
        end
        if (hsync && !hs_q) begin  // line sync starts
            hs_len = 0;
            if (capturing) n_hs++;
        end
        if (hsync) begin
            hs_len++;
        end else if (hs_q && capturing) begin  // line sync just ended
            check_sync_width();
        end
        de_q = de;
        vs_q = vsync;
        hs_q = hsync;
    end
endmodule

`default_nettype wire

//--- gfx_ifs.sv
/* grouped connections inside the graphics core: rectangle commands from the
   controller to the filler, and pixel writes from the filler to the canvas */
`default_nettype none
`timescale 1ns/1ps

interface draw_cmd_if;
    import gfx_pkg::*;
    logic      valid;   // held with stable fields until ready
    logic      ready;   // low while a fill runs
    canv_x_t   x0, x1;
    canv_y_t   y0, y1;
    colr_idx_t colr;
    modport source (output valid, x0, y0, x1, y1, colr, input ready);
    modport sink (input valid, x0, y0, x1, y1, colr, output ready);
endinterface

interface canvas_wr_if;
    import gfx_pkg::*;
    logic      wr_en;  // write only, never stalled
    canv_x_t   wr_x;
    canv_y_t   wr_y;
    colr_idx_t wr_colr;
    modport source (output wr_en, wr_x, wr_y, wr_colr);
    modport sink (input wr_en, wr_x, wr_y, wr_colr);
endinterface

`default_nettype wire

//--- gfx_pkg.sv
/* shared widths, APB register map and draw FSM states for the graphics subsystem
   imported by the RTL modules and interfaces that need them */
`default_nettype none

package gfx_pkg;
    localparam int CANV_W  = 64;  // canvas width in pixels
    localparam int CANV_H  = 32;  // canvas height in lines
    localparam int CMD_MAX = 16;  // command list and palette depth

    typedef logic [5:0]  canv_x_t;     // canvas column
    typedef logic [4:0]  canv_y_t;     // canvas row
    typedef logic [3:0]  colr_idx_t;   // palette index, 4 bpp
    typedef logic [14:0] rgb555_t;     // red [14:10], green [9:5], blue [4:0]
    typedef logic [10:0] canv_addr_t;  // row * 64 + column
    typedef logic [31:0] cmd_word_t;   // {6'b0, x0, y0, x1, y1, colr}
    typedef logic [3:0]  cmd_idx_t;
    typedef logic [4:0]  cmd_cnt_t;    // 0..16 commands
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // APB byte offsets
    localparam apb_addr_t REG_CTRL      = 8'h00;  // bit 0 start, write-one
    localparam apb_addr_t REG_STATUS    = 8'h04;  // bit 0 busy, bit 1 done
    localparam apb_addr_t REG_BG        = 8'h08;
    localparam apb_addr_t REG_CMD_COUNT = 8'h0C;
    localparam apb_addr_t PAL_BASE      = 8'h40;  // 16 entries up to 0x7C
    localparam apb_addr_t CMD_BASE      = 8'h80;  // 16 entries up to 0xBC

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        ISSUE,
        WAIT_FILL,
        DONE
    } draw_state_t;
endpackage

`default_nettype wire

//--- gfx_top.f
gfx_pkg.sv
gfx_ifs.sv
gfx_apb_regs.sv
draw_ctrl.sv
rect_fill.sv
canvas_ram.sv
display_scan.sv
gfx_top.sv
gfx_checker.sv
tb_gfx_top.sv

//--- gfx_top.sv
/* graphics subsystem top: APB register port in, video timing and 8-bit RGB out,
   all on clk_sys; sets the display mode for the scanner */
`default_nettype none
`timescale 1ns/1ps

module gfx_top #(
    parameter int H_ACTIVE     = 160,  // small test mode
    parameter int H_TOTAL      = 200,
    parameter int H_SYNC_START = 168,
    parameter int H_SYNC_LEN   = 16,
    parameter int V_ACTIVE     = 80,
    parameter int V_TOTAL      = 90,
    parameter int V_SYNC_START = 82,
    parameter int V_SYNC_LEN   = 2,
    parameter int CANV_SCALE   = 2,    // canvas shown at 128x64
    parameter int WIN_STARTX   = 16,
    parameter int WIN_STARTY   = 8
) (
    input  logic        clk_sys,
    input  logic        rst_sys,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue
);
    import gfx_pkg::*;

    logic       start, busy, done;
    cmd_cnt_t   cmd_count;
    cmd_idx_t   cmd_idx;
    cmd_word_t  cmd_word;
    rgb555_t    bg_colr, pal_colr;
    colr_idx_t  pal_idx, rd_colr;
    canv_addr_t rd_addr;

    draw_cmd_if  cmd_bus ();   // controller to filler
    canvas_wr_if wr_bus ();    // filler to canvas

    gfx_apb_regs regs_inst (
        .clk_sys(clk_sys), .rst_sys(rst_sys),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .cmd_count(cmd_count), .cmd_idx(cmd_idx), .cmd_word(cmd_word),
        .busy(busy), .done(done),
        .bg_colr(bg_colr), .pal_idx(pal_idx), .pal_colr(pal_colr)
    );

    draw_ctrl ctrl_inst (
        .clk_sys(clk_sys), .rst_sys(rst_sys),
        .start(start), .cmd_count(cmd_count), .cmd_idx(cmd_idx), .cmd_word(cmd_word),
        .busy(busy), .done(done), .cmd(cmd_bus)
    );

    rect_fill fill_inst (.clk_sys(clk_sys), .rst_sys(rst_sys), .cmd(cmd_bus), .wr(wr_bus));

    canvas_ram canvas_inst (
        .clk_sys(clk_sys), .wr(wr_bus), .rd_addr(rd_addr), .rd_colr(rd_colr)
    );

    display_scan #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
        .CANV_SCALE(CANV_SCALE), .WIN_STARTX(WIN_STARTX), .WIN_STARTY(WIN_STARTY)
    ) scan_inst (
        .clk_sys(clk_sys), .rst_sys(rst_sys),
        .rd_addr(rd_addr), .rd_colr(rd_colr), .pal_idx(pal_idx), .pal_colr(pal_colr),
        .bg_colr(bg_colr), .hsync(hsync), .vsync(vsync), .de(de),
        .red(red), .green(green), .blue(blue)
    );
endmodule

`default_nettype wire

//--- gfx_vectors.txt
# W addr data pslverr, R addr data pslverr (hex); S draw and poll; F check queued points
# P x y red green blue (decimal); X random palette write and read back
R 04 0 0
R 00 0 0
W 40 1234 0
R 40 1234 0
W 44 ffffffff 0
R 44 7fff 0
W 08 7fff 0
R 08 7fff 0
W 80 00a2a8c1 0
R 80 00a2a8c1 0
W 0c 14 0
R 0c 10 0
W f0 5 1
R f0 0 1
W 04 3 1
R 04 0 0
X
# empty command list still ends with done
W 0c 0 0
S
R 04 2 0
# palette 0 black, 1 red, 2 green, 3 grey at 0x10 per channel
W 40 0 0
W 44 7c00 0
W 48 3e0 0
W 4c 4210 0
# clear, rect A colour 1, rect B colour 3 over A, reversed rect colour 2
W 80 7ff0 0
W 84 00a2a8c1 0
W 88 012532f3 0
W 8c 028a3d92 0
W 0c 3 0
S
R 04 2 0
W 0c 4 0
S
R 04 2 0
P 46 24 255 0 0
P 36 18 255 0 0
P 37 33 255 0 0
P 57 19 255 0 0
P 56 32 132 132 132
P 54 30 132 132 132
P 67 39 132 132 132
P 34 18 0 0 0
P 58 18 0 0 0
P 36 16 0 0 0
P 68 38 0 0 0
P 86 52 0 0 0
P 76 48 0 0 0
P 5 30 255 255 255
P 150 20 255 255 255
P 50 75 255 255 255
F

//--- rect_fill.sv
/* rectangle filler: takes one command and writes its colour into the canvas,
   one pixel per cycle, left to right and top to bottom */
`default_nettype none
`timescale 1ns/1ps

module rect_fill (
    input  logic        clk_sys,
    input  logic        rst_sys,
    draw_cmd_if.sink    cmd,
    canvas_wr_if.source wr
);
    import gfx_pkg::*;

    logic      filling;
    canv_x_t   rx0, rx1, cur_x;   // latched bounds and walking column
    canv_y_t   ry0, ry1, cur_y;
    colr_idx_t rcolr;

    assign cmd.ready  = !filling;  // back-pressure while a fill runs
    assign wr.wr_en   = filling;
    assign wr.wr_x    = cur_x;
    assign wr.wr_y    = cur_y;
    assign wr.wr_colr = rcolr;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            filling <= 1'b0;
        end else if (!filling) begin
            if (cmd.valid) begin  // accept and latch
                rx0     <= cmd.x0;
                rx1     <= cmd.x1;
                ry0     <= cmd.y0;
                ry1     <= cmd.y1;
                rcolr   <= cmd.colr;
                cur_x   <= cmd.x0;
                cur_y   <= cmd.y0;
                filling <= 1'b1;
            end
        end else if (cur_x == rx1) begin  // end of row
            cur_x <= rx0;
            cur_y <= cur_y + 1'b1;
            if (cur_y == ry1) filling <= 1'b0;  // last pixel this cycle
        end else begin
            cur_x <= cur_x + 1'b1;
        end
    end

    a_in_rect: assert property (@(posedge clk_sys) disable iff (rst_sys)
        wr.wr_en |-> (wr.wr_x >= rx0 && wr.wr_x <= rx1 && wr.wr_y >= ry0 && wr.wr_y <= ry1))
        else $error("rect_fill: write at (%0d,%0d) outside rectangle", wr.wr_x, wr.wr_y);
endmodule

`default_nettype wire

//--- tb_gfx_top.sv
/* testbench for gfx_top: replays gfx_vectors.txt over APB, runs draws, and has
   gfx_checker compare register reads and display pixels */
`default_nettype none
`timescale 1ns/1ps

module tb_gfx_top;
    logic        clk_sys;
    logic        rst_sys;
    logic [7:0]  paddr;
    logic        psel, penable, pwrite;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr, hsync, vsync, de;
    logic [7:0]  red, green, blue;
    logic [31:0] rd_data;    // last APB read, used for polling
    logic [31:0] rng;        // xorshift state
    logic        timed_out;
    int          n_tests, n_failed;

    gfx_top dut_i (.*);

    gfx_checker mon_i (
        .clk_sys(clk_sys), .prdata(prdata), .pslverr(pslverr), .de(de),
        .hsync(hsync), .vsync(vsync), .red(red), .green(green), .blue(blue)
    );

    always #10 clk_sys = ~clk_sys;  // 20 ns period

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_test(input string name, input int e0);
        n_tests++;
        if (mon_i.errors > e0 || timed_out) begin
            n_failed++;
            $display("test %0d, %s: errors found", n_tests, name);
        end else begin
            $display("test %0d, %s: ok", n_tests, name);
        end
    endtask

    // one APB transfer, setup then access, with an idle cycle after
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
            input logic chk, input logic [31:0] exp_data, input logic exp_err);
        int waits;
        waits = 0;
        @(posedge clk_sys);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_sys);
        #2;
        penable = 1'b1;
        #15;  // just before the completing edge
        while (!pready && waits < 16) begin
            @(posedge clk_sys);
            #17;
            waits++;
        end
        if (!pready) begin
            $display("timeout: pready stayed low at address 0x%02h", addr);
            timed_out = 1'b1;
        end
        mon_i.compare_response(addr, chk && !wr, exp_data, exp_err);
        rd_data = prdata;
        @(posedge clk_sys);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic run_draw();
        int cycles;
        int e0;
        e0 = mon_i.errors;
        apb_access(1'b1, 8'h00, 32'h1, 1'b0, '0, 1'b0);  // start
        rd_data = '0;
        cycles  = 0;
        while (!(rd_data[1] && !rd_data[0]) && cycles < 20000) begin  // until done, not busy
            apb_access(1'b0, 8'h04, '0, 1'b0, '0, 1'b0);
            cycles += 3;
        end
        if (!(rd_data[1] && !rd_data[0])) begin
            $display("timeout: drawing did not finish within 20000 cycles");
            timed_out = 1'b1;
        end
        report_test($sformatf("draw, done within %0d cycles", cycles), e0);
    endtask

    task automatic random_palette();
        logic [31:0] vals [16];
        int          e0;
        e0 = mon_i.errors;
        for (int i = 0; i < 16; i++) begin
            rng     = next_random(rng);
            vals[i] = rng & 32'h0000_7fff;  // RGB555 width
            apb_access(1'b1, 8'h40 + 8'(4 * i), vals[i], 1'b0, '0, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            apb_access(1'b0, 8'h40 + 8'(4 * i), '0, 1'b1, vals[i], 1'b0);
        end
        report_test("random palette, 16 entries", e0);
    endtask

    task automatic check_frame();
        int cycles;
        int e0;
        int pts;
        e0     = mon_i.errors;
        pts    = mon_i.n_pts;
        cycles = 0;
        mon_i.arm_frame();
        while (!mon_i.frame_done && cycles < 40000) begin
            @(posedge clk_sys);
            cycles++;
        end
        if (!mon_i.frame_done) begin
            $display("timeout: no complete video frame within 40000 cycles");
            timed_out = 1'b1;
        end
        report_test($sformatf("frame with %0d pixel points", pts), e0);
    endtask

    initial begin
        int               fd, n, e0;
        int               x, y, r, g, b;
        logic [63:0]      tok;        // operation letter or comment mark
        logic [8*160-1:0] rest;
        logic [31:0]      a, d, e;
        clk_sys   = 1'b0;
        rst_sys   = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        rd_data   = '0;
        rng       = 32'hd9ef2159;
        timed_out = 1'b0;
        n_tests   = 0;
        n_failed  = 0;
        repeat (16) @(posedge clk_sys);
        #2;
        rst_sys = 1'b0;
        fd = $fopen("gfx_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open gfx_vectors.txt");
            n_failed++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", tok) == 1) begin
                e0 = mon_i.errors;
                case (tok)
                    "#": n = $fgets(rest, fd);  // comment, skip the line
                    "W": begin
                        n = $fscanf(fd, "%h %h %h", a, d, e);
                        apb_access(1'b1, a[7:0], d, 1'b0, '0, e[0]);
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h %h", a, d, e);
                        apb_access(1'b0, a[7:0], '0, 1'b1, d, e[0]);
                        report_test($sformatf("read 0x%02h", a[7:0]), e0);
                    end
                    "S": run_draw();
                    "P": begin
                        n = $fscanf(fd, "%d %d %d %d %d", x, y, r, g, b);
                        mon_i.add_point(x, y, r[7:0], g[7:0], b[7:0]);
                    end
                    "F": check_frame();
                    "X": random_palette();
                    default: begin
                        $display("unknown operation in gfx_vectors.txt");
                        n_failed++;
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, mon_i.checks, mon_i.errors);
        if (n_failed == 0 && mon_i.errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire
